/* axi4_w_buffer.f */
w_buf_pkg.sv
w_beat_if.sv
w_fifo.sv
w_route_fsm.sv
axi4_w_buffer.sv
tb_axi4_w_buffer_sva.sv
tb_axi4_w_buffer.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the axi4_w_buffer testbench with Verilator, output goes to sim.log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_axi4_w_buffer \
  -f axi4_w_buffer.f > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_axi4_w_buffer > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation reported errors"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation finished cleanly"

/* tb_axi4_w_buffer.sv */
/* Random testbench with a fixed seed and a queue model of orders and bursts
   The Nth accepted order decides the Nth accepted burst */
`timescale 1ns/1ps

module tb_axi4_w_buffer import w_buf_pkg::*; ();

  localparam int N_FWD   = 10;
  localparam int N_DROP  = 6;
  localparam int N_MIX   = 20;
  localparam int N_BP    = ORDER_FIFO_DEPTH + 1;
  localparam int N_BURST = N_FWD + N_DROP + N_MIX + N_BP;

  logic                      axi4_aclk = 1'b0;
  logic                      axi4_arstn;
  logic                      l1_forward;
  logic                      l1_drop;
  logic                      l1_master;
  logic                      l1_prefetch;
  logic                      l1_hit;
  logic [AXI_ID_WIDTH-1:0]   l1_id;
  logic                      l1_done;
  logic                      input_stall;
  logic                      master_select;
  logic                      b_drop;
  logic                      b_done;
  logic                      prefetch;
  logic                      hit;
  logic [AXI_ID_WIDTH-1:0]   id;
  logic [AXI_DATA_WIDTH-1:0] s_wdata;
  logic [AXI_DATA_WIDTH-1:0] m_wdata;
  logic [AXI_STRB_WIDTH-1:0] s_wstrb;
  logic [AXI_STRB_WIDTH-1:0] m_wstrb;
  logic [AXI_USER_WIDTH-1:0] s_wuser;
  logic [AXI_USER_WIDTH-1:0] m_wuser;
  logic                      s_wlast;
  logic                      s_wvalid;
  logic                      s_wready;
  logic                      m_wlast;
  logic                      m_wvalid;
  logic                      m_wready = 1'b0;

  // Stimulus tables and reference model
  w_order_e op_arr [N_BURST];
  int       len_arr [N_BURST];
  w_order_t ord_q [$];
  w_beat_t  beat_q [$];
  string    test_name = "init";
  logic     drop_active = 1'b0;
  int       drop_cnt = 0;
  int       fwd_beats = 0;
  int       retired = 0;
  int       cycle_cnt = 0;
  int       cycle_limit = 0;

  axi4_w_buffer dut_i (
    .axi4_aclk       (axi4_aclk),
    .axi4_arstn      (axi4_arstn),
    .l1_forward_i    (l1_forward),
    .l1_drop_i       (l1_drop),
    .l1_master_i     (l1_master),
    .l1_id_i         (l1_id),
    .l1_prefetch_i   (l1_prefetch),
    .l1_hit_i        (l1_hit),
    .l1_done_o       (l1_done),
    .input_stall_o   (input_stall),
    .master_select_o (master_select),
    .b_drop_o        (b_drop),
    .b_done_i        (b_done),
    .id_o            (id),
    .prefetch_o      (prefetch),
    .hit_o           (hit),
    .s_axi4_wdata_i  (s_wdata),
    .s_axi4_wstrb_i  (s_wstrb),
    .s_axi4_wuser_i  (s_wuser),
    .s_axi4_wlast_i  (s_wlast),
    .s_axi4_wvalid_i (s_wvalid),
    .s_axi4_wready_o (s_wready),
    .m_axi4_wdata_o  (m_wdata),
    .m_axi4_wstrb_o  (m_wstrb),
    .m_axi4_wuser_o  (m_wuser),
    .m_axi4_wlast_o  (m_wlast),
    .m_axi4_wvalid_o (m_wvalid),
    .m_axi4_wready_i (m_wready)
  );

  bind w_route_fsm tb_axi4_w_buffer_sva sva_i (
    .axi4_aclk   (axi4_aclk),
    .axi4_arstn  (axi4_arstn),
    .m_beat_i    (m_beat_o),
    .m_valid_i   (m_valid_o),
    .m_ready_i   (m_ready_i),
    .b_drop_i    (b_drop_o),
    .b_done_i    (b_done_i),
    .buf_ready_i (buf_w.ready),
    .state_i     (state_q)
  );

  always #10 axi4_aclk = ~axi4_aclk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_beat(input string what, input w_beat_t exp, input w_beat_t act);
    if (exp !== act) begin
      abort_run($sformatf("CHECK FAILED %s %s expected %h actual %h",
                          test_name, what, exp, act));
    end
  endtask

  // Only the fields the B sender sees
  task automatic check_order(input string what, input w_order_t exp, input w_order_t act);
    if (exp.id !== act.id || exp.prefetch !== act.prefetch || exp.hit !== act.hit) begin
      abort_run($sformatf("CHECK FAILED %s %s expected %h actual %h", test_name, what,
                          {exp.id, exp.prefetch, exp.hit}, {act.id, act.prefetch, act.hit}));
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      abort_run($sformatf("CHECK FAILED %s %s expected %b actual %b",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (exp != act) begin
      abort_run($sformatf("CHECK FAILED %s %s expected %0d actual %0d",
                          test_name, what, exp, act));
    end
  endtask

  task automatic set_order(input int idx);
    l1_drop     <= (op_arr[idx] == ORDER_DROP);
    l1_forward  <= (op_arr[idx] == ORDER_FORWARD) ? 1'b1 : 1'($urandom % 2);
    l1_master   <= 1'($urandom % 2);
    l1_id       <= AXI_ID_WIDTH'($urandom);
    l1_prefetch <= 1'($urandom % 2);
    l1_hit      <= 1'($urandom % 2);
  endtask

  task automatic clear_order();
    l1_forward <= 1'b0;
    l1_drop    <= 1'b0;
  endtask

  task automatic issue_orders(input int first, input int count);
    int idle;
    for (int i = first; i < first + count; i++) begin
      idle = int'($urandom % 3);
      repeat (idle) begin
        @(posedge axi4_aclk);
        clear_order();
      end
      @(posedge axi4_aclk);
      set_order(i);
      do @(negedge axi4_aclk); while (!l1_done);
    end
    @(posedge axi4_aclk);
    clear_order();
  endtask

  task automatic issue_bursts(input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      for (int b = 0; b < len_arr[i]; b++) begin
        if ($urandom % 4 == 0) begin
          @(posedge axi4_aclk);
          s_wvalid <= 1'b0;
        end
        @(posedge axi4_aclk);
        s_wdata  <= $urandom;
        s_wstrb  <= AXI_STRB_WIDTH'($urandom);
        s_wuser  <= AXI_USER_WIDTH'($urandom);
        s_wlast  <= (b == len_arr[i] - 1);
        s_wvalid <= 1'b1;
        do @(negedge axi4_aclk); while (!s_wready);
      end
    end
    @(posedge axi4_aclk);
    s_wvalid <= 1'b0;
    s_wlast  <= 1'b0;
  endtask

  task automatic wait_drained();
    do @(negedge axi4_aclk); while (ord_q.size() != 0 || beat_q.size() != 0);
  endtask

  task automatic check_totals(input int first, input int count, input int drops_before,
                              input int beats_before);
    int exp_drops;
    int exp_beats;
    exp_drops = 0;
    exp_beats = 0;
    for (int i = first; i < first + count; i++) begin
      if (op_arr[i] == ORDER_DROP) begin
        exp_drops++;
      end else begin
        exp_beats += len_arr[i];
      end
    end
    check_count("drop handshakes", exp_drops, drop_cnt - drops_before);
    check_count("forwarded beats", exp_beats, fwd_beats - beats_before);
  endtask

  task automatic run_phase(input string name, input int first, input int count);
    int drops_before;
    int beats_before;
    test_name    = name;
    drops_before = drop_cnt;
    beats_before = fwd_beats;
    fork
      issue_orders(first, count);
      issue_bursts(first, count);
    join
    wait_drained();
    check_totals(first, count, drops_before, beats_before);
  endtask

  // Fill the order FIFO with the W side idle and release it with bursts
  task automatic run_backpressure(input int first);
    int retired_at_stall;
    int drops_before;
    int beats_before;
    test_name    = "order_backpressure";
    drops_before = drop_cnt;
    beats_before = fwd_beats;
    for (int i = first; i < first + ORDER_FIFO_DEPTH; i++) begin
      @(posedge axi4_aclk);
      set_order(i);
      @(negedge axi4_aclk);
      check_bit("l1_done_o", 1'b1, l1_done);
    end
    @(posedge axi4_aclk);
    set_order(first + ORDER_FIFO_DEPTH);
    repeat (3) begin
      @(negedge axi4_aclk);
      check_bit("input_stall_o", 1'b1, input_stall);
      check_bit("l1_done_o", 1'b0, l1_done);
    end
    retired_at_stall = retired;
    fork
      issue_bursts(first, N_BP);
      begin
        do @(negedge axi4_aclk); while (!l1_done);
        if (retired == retired_at_stall) begin
          abort_run("order accepted into a full order FIFO before any burst completed");
        end
        @(posedge axi4_aclk);
        clear_order();
      end
    join
    wait_drained();
    check_totals(first, N_BP, drops_before, beats_before);
  endtask

  // Reference model sampled on the falling edge where all outputs have settled
  always @(negedge axi4_aclk) begin : model_monitor
    w_order_t o;
    w_order_t seen;
    w_beat_t  b;
    logic     burst_end;
    if (axi4_arstn) begin
      seen          = '0;
      seen.id       = id;
      seen.prefetch = prefetch;
      seen.hit      = hit;
      if (m_wvalid) begin
        if (ord_q.size() == 0 || ord_q[0].opcode != ORDER_FORWARD) begin
          abort_run("beat on the master W channel without a forward order at the head");
        end else if (m_wready) begin
          b.data = m_wdata;
          b.strb = m_wstrb;
          b.user = m_wuser;
          b.last = m_wlast;
          if (beat_q.size() == 0) begin
            abort_run("master beat appeared that was never accepted on the slave side");
          end else begin
            check_beat("m_axi4 beat", beat_q[0], b);
            check_bit("master_select_o", ord_q[0].master, master_select);
            b = beat_q.pop_front();
            fwd_beats++;
            if (b.last) begin
              o = ord_q.pop_front();
              retired++;
            end
          end
        end
      end
      if (b_drop) begin
        if (!drop_active) begin
          drop_active = 1'b1;
          drop_cnt++;
          if (ord_q.size() == 0 || ord_q[0].opcode != ORDER_DROP) begin
            abort_run("b_drop_o raised without a drop order at the head");
          end else begin
            // The whole burst has been swallowed by now
            burst_end = 1'b0;
            while (!burst_end && beat_q.size() != 0) begin
              b = beat_q.pop_front();
              burst_end = b.last;
            end
            if (!burst_end) begin
              abort_run("b_drop_o raised before the dropped burst was complete");
            end
          end
        end
        if (ord_q.size() != 0) begin
          check_order("drop fields", ord_q[0], seen);
        end
        if (b_done && ord_q.size() != 0) begin
          o = ord_q.pop_front();
          retired++;
          drop_active = 1'b0;
        end
      end
      if (l1_done) begin
        o.opcode   = l1_drop ? ORDER_DROP : ORDER_FORWARD;
        o.master   = l1_master;
        o.id       = l1_id;
        o.prefetch = l1_prefetch;
        o.hit      = l1_hit;
        ord_q.push_back(o);
      end
      if (s_wvalid && s_wready) begin
        b.data = s_wdata;
        b.strb = s_wstrb;
        b.user = s_wuser;
        b.last = s_wlast;
        beat_q.push_back(b);
      end
    end
  end

  // Bound handshake assertions count their failures
  always @(negedge axi4_aclk) begin
    if (dut_i.route_fsm.sva_i.fail_cnt != 0) begin
      abort_run("handshake assertion failed in the routing FSM");
    end
  end

  always @(posedge axi4_aclk) begin
    m_wready <= ($urandom % 4 != 0);
  end

  // B sender answers each drop after a random wait
  initial begin : b_responder
    int wait_cycles;
    b_done <= 1'b0;
    forever begin
      @(negedge axi4_aclk);
      if (b_drop) begin
        wait_cycles = int'($urandom % 6);
        repeat (wait_cycles) @(negedge axi4_aclk);
        @(posedge axi4_aclk);
        b_done <= 1'b1;
        @(posedge axi4_aclk);
        b_done <= 1'b0;
      end
    end
  end

  always @(posedge axi4_aclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      abort_run($sformatf("timeout, run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin : main
    int total_beats;
    void'($urandom(32'h3b0d));
    axi4_arstn  <= 1'b0;
    l1_forward  <= 1'b0;
    l1_drop     <= 1'b0;
    l1_master   <= 1'b0;
    l1_id       <= '0;
    l1_prefetch <= 1'b0;
    l1_hit      <= 1'b0;
    s_wdata     <= '0;
    s_wstrb     <= '0;
    s_wuser     <= '0;
    s_wlast     <= 1'b0;
    s_wvalid    <= 1'b0;
    total_beats = 0;
    for (int i = 0; i < N_BURST; i++) begin
      len_arr[i] = 1 + int'($urandom % 8);
      if (i < N_FWD) begin
        op_arr[i] = ORDER_FORWARD;
      end else if (i < N_FWD + N_DROP) begin
        op_arr[i] = ORDER_DROP;
      end else if (i < N_FWD + N_DROP + N_MIX) begin
        op_arr[i] = ($urandom % 2 == 0) ? ORDER_FORWARD : ORDER_DROP;
      end else begin
        op_arr[i] = ORDER_FORWARD;
      end
      total_beats += len_arr[i];
    end
    cycle_limit = 4 * (total_beats + N_BURST) + 1000;

    test_name = "reset";
    repeat (5) @(posedge axi4_aclk);
    axi4_arstn <= 1'b1;
    @(negedge axi4_aclk);
    check_bit("m_axi4_wvalid_o", 1'b0, m_wvalid);
    check_bit("b_drop_o", 1'b0, b_drop);
    check_bit("l1_done_o", 1'b0, l1_done);
    check_bit("input_stall_o", 1'b0, input_stall);
    check_bit("s_axi4_wready_o", 1'b1, s_wready);

    run_phase("forwarding", 0, N_FWD);
    run_phase("dropping", N_FWD, N_DROP);
    run_phase("mixed", N_FWD + N_DROP, N_MIX);
    run_backpressure(N_FWD + N_DROP + N_MIX);

    if (dut_i.route_fsm.sva_i.fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("SOME TESTS FAILED");
      $fatal(1, "run ended with handshake assertion failures");
    end
  end

endmodule

/* tb_axi4_w_buffer_sva.sv */
/* Handshake rules of the routing FSM, bound into w_route_fsm
   Assumes the head order does not change while a beat waits */
`timescale 1ns/1ps

module tb_axi4_w_buffer_sva import w_buf_pkg::*; (
  input logic         axi4_aclk,
  input logic         axi4_arstn,
  input w_beat_t      m_beat_i,
  input logic         m_valid_i,
  input logic         m_ready_i,
  input logic         b_drop_i,
  input logic         b_done_i,
  input logic         buf_ready_i,
  input route_state_e state_i
);

  // Count of failed assertions for the testbench
  int fail_cnt = 0;

  // Master beat and valid hold until the master takes them
  property m_valid_held;
    @(posedge axi4_aclk) disable iff (!axi4_arstn)
      m_valid_i && !m_ready_i |=> m_valid_i && $stable(m_beat_i);
  endproperty

  // Drop request waits for the B sender
  property b_drop_held;
    @(posedge axi4_aclk) disable iff (!axi4_arstn)
      b_drop_i && !b_done_i |=> b_drop_i;
  endproperty

  // Buffer stays frozen during the drop handshake
  property no_pop_in_handshake;
    @(posedge axi4_aclk) disable iff (!axi4_arstn)
      state_i == B_HANDSHAKE |-> !buf_ready_i && !m_valid_i;
  endproperty

  assert property (m_valid_held)
    else begin
      fail_cnt++;
      $error("m_valid_o or m_beat_o changed before m_ready_i");
    end
  assert property (b_drop_held)
    else begin
      fail_cnt++;
      $error("b_drop_o fell before b_done_i");
    end
  assert property (no_pop_in_handshake)
    else begin
      fail_cnt++;
      $error("beat buffer moved during the drop handshake");
    end

endmodule

/* axi4_w_buffer.sv */
/* W data buffer behind a single TLB, one order per burst in arrival order
   Drop wins when l1_forward_i and l1_drop_i are high together */
`timescale 1ns/1ps

module axi4_w_buffer import w_buf_pkg::*; (
  input  logic                      axi4_aclk,
  input  logic                      axi4_arstn,

  // Orders from the TLB
  input  logic                      l1_forward_i,
  input  logic                      l1_drop_i,
  input  logic                      l1_master_i,
  input  logic [AXI_ID_WIDTH-1:0]   l1_id_i,
  input  logic                      l1_prefetch_i,
  input  logic                      l1_hit_i,
  output logic                      l1_done_o,
  output logic                      input_stall_o,
  output logic                      master_select_o,

  // B sender
  output logic                      b_drop_o,
  input  logic                      b_done_i,
  output logic [AXI_ID_WIDTH-1:0]   id_o,
  output logic                      prefetch_o,
  output logic                      hit_o,

  // Slave W channel
  input  logic [AXI_DATA_WIDTH-1:0] s_axi4_wdata_i,
  input  logic [AXI_STRB_WIDTH-1:0] s_axi4_wstrb_i,
  input  logic [AXI_USER_WIDTH-1:0] s_axi4_wuser_i,
  input  logic                      s_axi4_wlast_i,
  input  logic                      s_axi4_wvalid_i,
  output logic                      s_axi4_wready_o,

  // Master W channel
  output logic [AXI_DATA_WIDTH-1:0] m_axi4_wdata_o,
  output logic [AXI_STRB_WIDTH-1:0] m_axi4_wstrb_o,
  output logic [AXI_USER_WIDTH-1:0] m_axi4_wuser_o,
  output logic                      m_axi4_wlast_o,
  output logic                      m_axi4_wvalid_o,
  input  logic                      m_axi4_wready_i
);

  w_beat_if in_w ();
  w_beat_if buf_w ();

  w_order_t order_in;
  w_order_t order_head;
  logic     order_req;
  logic     order_push_ready;
  logic     order_head_valid;
  logic     order_pop;
  w_beat_t  m_beat;

  // Slave pins onto the input stream
  assign in_w.beat.data   = s_axi4_wdata_i;
  assign in_w.beat.strb   = s_axi4_wstrb_i;
  assign in_w.beat.user   = s_axi4_wuser_i;
  assign in_w.beat.last   = s_axi4_wlast_i;
  assign in_w.valid       = s_axi4_wvalid_i;
  assign s_axi4_wready_o  = in_w.ready;

  w_fifo #(
    .DEPTH   (INPUT_BUFFER_DEPTH),
    .entry_t (w_beat_t)
  ) beat_buf (
    .axi4_aclk    (axi4_aclk),
    .axi4_arstn   (axi4_arstn),
    .push_data_i  (in_w.beat),
    .push_valid_i (in_w.valid),
    .push_ready_o (in_w.ready),
    .pop_data_o   (buf_w.beat),
    .pop_valid_o  (buf_w.valid),
    .pop_ready_i  (buf_w.ready)
  );

  // Build the order, drop has priority over forward
  assign order_req         = l1_forward_i | l1_drop_i;
  assign order_in.opcode   = l1_drop_i ? ORDER_DROP : ORDER_FORWARD;
  assign order_in.master   = l1_master_i;
  assign order_in.id       = l1_id_i;
  assign order_in.prefetch = l1_prefetch_i;
  assign order_in.hit      = l1_hit_i;

  // Order is stored in the same cycle that l1_done_o is seen
  assign l1_done_o     = order_req & order_push_ready;
  assign input_stall_o = ~order_push_ready;

  w_fifo #(
    .DEPTH   (ORDER_FIFO_DEPTH),
    .entry_t (w_order_t)
  ) order_fifo (
    .axi4_aclk    (axi4_aclk),
    .axi4_arstn   (axi4_arstn),
    .push_data_i  (order_in),
    .push_valid_i (order_req),
    .push_ready_o (order_push_ready),
    .pop_data_o   (order_head),
    .pop_valid_o  (order_head_valid),
    .pop_ready_i  (order_pop)
  );

  w_route_fsm route_fsm (
    .axi4_aclk       (axi4_aclk),
    .axi4_arstn      (axi4_arstn),
    .buf_w           (buf_w),
    .order_i         (order_head),
    .order_valid_i   (order_head_valid),
    .order_ready_o   (order_pop),
    .m_beat_o        (m_beat),
    .m_valid_o       (m_axi4_wvalid_o),
    .m_ready_i       (m_axi4_wready_i),
    .master_select_o (master_select_o),
    .b_drop_o        (b_drop_o),
    .b_done_i        (b_done_i)
  );

  // Drop handshake fields come from the head order
  assign id_o       = order_head.id;
  assign prefetch_o = order_head.prefetch;
  assign hit_o      = order_head.hit;

  assign m_axi4_wdata_o = m_beat.data;
  assign m_axi4_wstrb_o = m_beat.strb;
  assign m_axi4_wuser_o = m_beat.user;
  assign m_axi4_wlast_o = m_beat.last;

endmodule

/* w_route_fsm.sv */
/* Forwards or discards the head burst as the head order says
   A dropped burst is only retired once the B sender answers b_done_i */
`timescale 1ns/1ps

module w_route_fsm import w_buf_pkg::*; (
  input  logic          axi4_aclk,
  input  logic          axi4_arstn,

  // Beats from the input buffer
  w_beat_if.sink        buf_w,

  // Head of the order FIFO
  input  w_order_t      order_i,
  input  logic          order_valid_i,
  output logic          order_ready_o,

  // Master W channel
  output w_beat_t       m_beat_o,
  output logic          m_valid_o,
  input  logic          m_ready_i,
  output logic          master_select_o,

  // Drop handshake with the B sender
  output logic          b_drop_o,
  input  logic          b_done_i
);

  route_state_e state_q;
  route_state_e state_d;
  logic         fwd_order;
  logic         drop_order;
  logic         fwd_last;
  logic         drop_last;

  // Decode the head order
  assign fwd_order  = order_valid_i && (order_i.opcode == ORDER_FORWARD);
  assign drop_order = order_valid_i && (order_i.opcode == ORDER_DROP);

  // Last beat of the burst leaves the buffer this cycle
  assign fwd_last  = buf_w.valid & buf_w.beat.last & m_ready_i;
  assign drop_last = buf_w.valid & buf_w.beat.last;

  // Port select is only meaningful with an order at the head
  assign master_select_o = order_valid_i & order_i.master;

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      state_q <= ROUTE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d       = state_q;
    m_beat_o      = '0;
    m_valid_o     = 1'b0;
    buf_w.ready   = 1'b0;
    order_ready_o = 1'b0;
    b_drop_o      = 1'b0;

    case (state_q)
      ROUTE: begin
        if (fwd_order) begin
          // Pass the beat through, buffer ready follows the master
          m_beat_o      = buf_w.beat;
          m_valid_o     = buf_w.valid;
          buf_w.ready   = m_ready_i;
          // Retire the order with the last beat
          order_ready_o = fwd_last;
        end else if (drop_order) begin
          // Swallow the whole burst
          buf_w.ready = 1'b1;
          if (drop_last) begin
            state_d = B_HANDSHAKE;
          end
        end
      end

      B_HANDSHAKE: begin
        // Nothing moves until the B sender has taken the drop
        b_drop_o = 1'b1;
        if (b_done_i) begin
          order_ready_o = 1'b1;
          state_d       = ROUTE;
        end
      end

      default: begin
        state_d = ROUTE;
      end
    endcase
  end

endmodule

/* w_fifo.sv */
/* Registered circular FIFO, DEPTH of 2 or more
   Push ready follows occupancy only, a full FIFO takes nothing until it pops */
`timescale 1ns/1ps

module w_fifo #(
  parameter int  DEPTH   = 4,
  parameter type entry_t = logic [7:0]
) (
  input  logic   axi4_aclk,
  input  logic   axi4_arstn,

  input  entry_t push_data_i,
  input  logic   push_valid_i,
  output logic   push_ready_o,

  output entry_t pop_data_o,
  output logic   pop_valid_o,
  input  logic   pop_ready_i
);

  entry_t                   mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH):0]   count;
  logic                     push;
  logic                     pop;

  // Flags come straight from the occupancy count
  assign push_ready_o = (int'(count) != DEPTH);
  assign pop_valid_o  = (count != '0);
  assign pop_data_o   = mem[rd_ptr];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  // Entry written now is at the head next cycle when the FIFO was empty
  always_ff @(posedge axi4_aclk) begin
    if (push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at DEPTH, which need not be a power of two
      if (push) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end

      // Simultaneous push and pop leaves the count unchanged
      case ({push, pop})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

endmodule

/* w_beat_if.sv */
/* One W beat stream with valid/ready
   The source holds beat and valid until the transfer */
`timescale 1ns/1ps

interface w_beat_if import w_buf_pkg::*; ();

  w_beat_t beat;
  logic    valid;
  logic    ready;

  // Producer side drives the payload and valid
  modport source (
    output beat,
    output valid,
    input  ready
  );

  // Consumer side answers with ready
  modport sink (
    input  beat,
    input  valid,
    output ready
  );

endinterface

/* w_buf_pkg.sv */
/* Shared widths, depths and types of the W buffer
   Widths are fixed here, so every block is built for the same 32-bit word */
package w_buf_pkg;

  // Bus widths
  localparam int AXI_DATA_WIDTH = 32;
  localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;
  localparam int AXI_ID_WIDTH   = 4;
  localparam int AXI_USER_WIDTH = 4;

  // Buffer depths
  localparam int INPUT_BUFFER_DEPTH = 4;
  localparam int ORDER_FIFO_DEPTH   = 8;

  // One W beat, 41 bits
  typedef struct packed {
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [AXI_STRB_WIDTH-1:0] strb;
    logic [AXI_USER_WIDTH-1:0] user;
    logic                      last;
  } w_beat_t;

  // What to do with the burst at the head of the beat buffer
  typedef enum logic {
    ORDER_FORWARD = 1'b0,
    ORDER_DROP    = 1'b1
  } w_order_e;

  // One translation order, 8 bits
  typedef struct packed {
    w_order_e                opcode;
    logic                    master;
    logic [AXI_ID_WIDTH-1:0] id;
    logic                    prefetch;
    logic                    hit;
  } w_order_t;

  // Routing FSM states
  typedef enum logic {
    ROUTE       = 1'b0,
    B_HANDSHAKE = 1'b1
  } route_state_e;

endpackage
